// File: hw/gfx_defines.svh
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

////////////////////////////////////////////////////////////
// field widths
////////////////////////////////////////////////////////////

`define GFX_X_W         10      // pixel column, up to 1024 across
`define GFX_Y_W         9       // row, up to 512 down
`define GFX_ADDR_W      18      // sram word address, two pixels per word
`define GFX_WORD_W      16      // cpu bus and register width
`define GFX_COLOUR_W    8       // palette index held per pixel
`define GFX_PAL_ADDR_W  6       // 64 palette entries
`define GFX_RGB_W       24      // 00RRGGBB minus the top byte
`define GFX_OFFSET_W    7       // word offset, byte address bits 7:1

// register word offsets
`define REG_CMD         7'd0
`define REG_X1          7'd1
`define REG_Y1          7'd2
`define REG_X2          7'd3
`define REG_Y2          7'd4
`define REG_COLOUR      7'd7

// command codes written to REG_CMD
`define CMD_HLINE       16'h0001
`define CMD_VLINE       16'h0002
`define CMD_PUTPIXEL    16'h000A
`define CMD_GETPIXEL    16'h000B
`define CMD_PALETTE     16'h0010

// reset values, everything else comes up as zero
`define RST_X2          16'h0400    // full width, 1024
`define RST_Y2          16'h0200    // full height, 512
`define RST_COLOUR      16'h0004    // palette entry 4

`endif

// File: hw/gfxPkg.sv
`default_nettype none
`include "gfx_defines.svh"

package gfxPkg;

	////////////////////////////////////////////////////////////
	// plain vectors with a meaning
	////////////////////////////////////////////////////////////

	typedef logic [`GFX_WORD_W-1:0]     word_t;     // one register or bus word
	typedef logic [`GFX_X_W-1:0]        pixX_t;     // pixel column
	typedef logic [`GFX_Y_W-1:0]        pixY_t;     // pixel row
	typedef logic [`GFX_ADDR_W-1:0]     sramAddr_t; // {row, column 9:1}
	typedef logic [`GFX_COLOUR_W-1:0]   colour_t;   // palette index
	typedef logic [`GFX_PAL_ADDR_W-1:0] palAddr_t;
	typedef logic [`GFX_RGB_W-1:0]      rgb_t;

	// draw engine states
	typedef enum logic [3:0] {
		sIdle,
		sDispatch,      // decode the command register
		sPutPixel,
		sGetPixel,      // read request goes out here
		sGetWait,       // sram latching the address
		sGetLatch,      // read pixel valid, colour latch loads
		sHLine,
		sVLine,
		sPalette        // hold until vertical sync
	} gfxState_t;

	////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////

	// 68000 style bus, strobes active low
	typedef struct packed {
		word_t address;
		word_t writeData;
		logic  csN;
		logic  asN;
		logic  udsN;    // upper byte lane
		logic  ldsN;    // lower byte lane
		logic  rw;      // 1 = read
	} cpuBus_t;

	typedef struct packed {
		word_t x1;
		word_t y1;
		word_t x2;
		word_t y2;
		word_t colour;
		word_t command;
	} drawRegs_t;

	// one pixel access, write and read are single cycle strobes
	typedef struct packed {
		logic    write;
		logic    read;
		pixX_t   x;
		pixY_t   y;
		colour_t colour;
	} pixelReq_t;

	typedef struct packed {
		sramAddr_t addr;
		word_t     wdata;
		logic      udsN;
		logic      ldsN;
		logic      rw;
	} sramReq_t;

	typedef struct packed {
		logic     we;
		palAddr_t addr;
		rgb_t     rgb;
	} palWrite_t;

endpackage

`default_nettype wire

// File: hw/gfxRegFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defines.svh"

module gfxRegFile (
	input  wire logic              Clk,
	input  wire logic              rstN,
	input  wire gfxPkg::cpuBus_t   bus,
	input  wire logic              done,       // sequencer back in idle
	input  wire gfxPkg::colour_t   readPixel,
	input  wire logic              readValid,
	output gfxPkg::drawRegs_t      regs,
	output logic                   start,
	output gfxPkg::word_t          readData
);

	logic [`GFX_OFFSET_W-1:0] offset;
	logic pageHit;                  // address inside our 256 byte window
	logic wrSel;
	logic rdSel;
	logic commandPending;           // command written, not yet started
	logic idle;                     // status bit 0
	gfxPkg::colour_t colourLatch;   // last pixel read back

	// merge the enabled byte lanes of a bus write into a register
	function automatic gfxPkg::word_t laneMerge(
		input gfxPkg::word_t oldVal,
		input gfxPkg::word_t newVal,
		input logic          udsN,
		input logic          ldsN
	);
		gfxPkg::word_t res;
		res = oldVal;
		if (!udsN)
			res[15:8] = newVal[15:8];
		if (!ldsN)
			res[7:0] = newVal[7:0];
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	assign offset  = bus.address[7:1];  // registers sit on word boundaries
	assign pageHit = (bus.address[15:8] == 8'h00);
	assign wrSel   = !bus.csN && !bus.asN && !bus.rw && pageHit;
	assign rdSel   = !bus.csN && !bus.asN && bus.rw && pageHit;

	// byte lane register writes, repeated each cycle the strobe is held
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '{
				x1:      '0,
				y1:      '0,
				x2:      `RST_X2,
				y2:      `RST_Y2,
				colour:  `RST_COLOUR,
				command: '0
			};
		end else if (wrSel) begin
			case (offset)
				`REG_CMD:    regs.command <= laneMerge(regs.command, bus.writeData,
				                                       bus.udsN, bus.ldsN);
				`REG_X1:     regs.x1 <= laneMerge(regs.x1, bus.writeData, bus.udsN, bus.ldsN);
				`REG_Y1:     regs.y1 <= laneMerge(regs.y1, bus.writeData, bus.udsN, bus.ldsN);
				`REG_X2:     regs.x2 <= laneMerge(regs.x2, bus.writeData, bus.udsN, bus.ldsN);
				`REG_Y2:     regs.y2 <= laneMerge(regs.y2, bus.writeData, bus.udsN, bus.ldsN);
				`REG_COLOUR: regs.colour <= laneMerge(regs.colour, bus.writeData,
				                                      bus.udsN, bus.ldsN);
				default:     ;  // unmapped offsets ignored
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// command handshake and status
	////////////////////////////////////////////////////////////

	// wait for AS to go high so the command write has fully landed
	assign start = commandPending && idle && bus.asN;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			commandPending <= 1'b0;
		else if (wrSel && offset == `REG_CMD)
			commandPending <= 1'b1;
		else if (start)
			commandPending <= 1'b0;     // consumed by the sequencer
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			idle <= 1'b1;
		else if (start)
			idle <= 1'b0;               // busy from the first engine cycle
		else if (done)
			idle <= 1'b1;
	end

	always_ff @(posedge Clk) begin
		if (readValid)
			colourLatch <= readPixel;   // get pixel result
	end

	// read back, zero when not selected
	always_comb begin
		readData = '0;
		if (rdSel) begin
			case (offset)
				`REG_CMD:    readData = {{(`GFX_WORD_W-1){1'b0}}, idle};
				`REG_COLOUR: readData = {{(`GFX_WORD_W-`GFX_COLOUR_W){1'b0}}, colourLatch};
				default:     readData = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/drawSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defines.svh"

module drawSequencer (
	input  wire logic              Clk,
	input  wire logic              rstN,
	input  wire gfxPkg::drawRegs_t regs,
	input  wire logic              start,
	input  wire logic              vsyncN,
	output gfxPkg::pixelReq_t      pixReq,
	output gfxPkg::palWrite_t      pal,
	output logic                   done
);

	gfxPkg::gfxState_t state;
	gfxPkg::gfxState_t nextState;
	gfxPkg::pixX_t colCnt;      // current column of a span
	gfxPkg::pixY_t rowCnt;      // current row of a span
	gfxPkg::pixX_t xEnd;        // last column, max(x1, x2)
	gfxPkg::pixY_t yEnd;        // last row, max(y1, y2)
	logic palWe;
	gfxPkg::palAddr_t palAddr;
	gfxPkg::rgb_t palRgb;

	// a reversed span collapses to the single start point
	assign xEnd = (regs.x2[`GFX_X_W-1:0] > regs.x1[`GFX_X_W-1:0]) ?
	              regs.x2[`GFX_X_W-1:0] : regs.x1[`GFX_X_W-1:0];
	assign yEnd = (regs.y2[`GFX_Y_W-1:0] > regs.y1[`GFX_Y_W-1:0]) ?
	              regs.y2[`GFX_Y_W-1:0] : regs.y1[`GFX_Y_W-1:0];

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			state <= gfxPkg::sIdle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = gfxPkg::sIdle;  // most states finish in one cycle
		case (state)
			gfxPkg::sIdle:
				nextState = start ? gfxPkg::sDispatch : gfxPkg::sIdle;
			gfxPkg::sDispatch: begin
				case (regs.command)
					`CMD_HLINE:    nextState = gfxPkg::sHLine;
					`CMD_VLINE:    nextState = gfxPkg::sVLine;
					`CMD_PUTPIXEL: nextState = gfxPkg::sPutPixel;
					`CMD_GETPIXEL: nextState = gfxPkg::sGetPixel;
					`CMD_PALETTE:  nextState = gfxPkg::sPalette;
					default:       nextState = gfxPkg::sIdle;  // unknown, drop it
				endcase
			end
			gfxPkg::sPutPixel: nextState = gfxPkg::sIdle;
			gfxPkg::sGetPixel: nextState = gfxPkg::sGetWait;
			gfxPkg::sGetWait:  nextState = gfxPkg::sGetLatch;
			gfxPkg::sGetLatch: nextState = gfxPkg::sIdle;
			gfxPkg::sHLine:
				nextState = (colCnt >= xEnd) ? gfxPkg::sIdle : gfxPkg::sHLine;
			gfxPkg::sVLine:
				nextState = (rowCnt >= yEnd) ? gfxPkg::sIdle : gfxPkg::sVLine;
			gfxPkg::sPalette:
				// only touch the palette during blanking to avoid flicker
				nextState = !vsyncN ? gfxPkg::sIdle : gfxPkg::sPalette;
			default: nextState = gfxPkg::sIdle;
		endcase
	end

	// last cycle of any command
	assign done = (state != gfxPkg::sIdle) && (nextState == gfxPkg::sIdle);

	////////////////////////////////////////////////////////////
	// span counters
	////////////////////////////////////////////////////////////

	// loaded at dispatch so single pixel commands use them too
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			colCnt <= '0;
			rowCnt <= '0;
		end else begin
			if (state == gfxPkg::sDispatch) begin
				colCnt <= regs.x1[`GFX_X_W-1:0];
				rowCnt <= regs.y1[`GFX_Y_W-1:0];
			end
			if (state == gfxPkg::sHLine)
				colCnt <= colCnt + 1'b1;    // one pixel per clock
			if (state == gfxPkg::sVLine)
				rowCnt <= rowCnt + 1'b1;
		end
	end

	// pixel strobes with the current coordinates
	always_comb begin
		pixReq.write  = (state == gfxPkg::sPutPixel) || (state == gfxPkg::sHLine) ||
		                (state == gfxPkg::sVLine);
		pixReq.read   = (state == gfxPkg::sGetPixel);
		pixReq.x      = colCnt;     // stays at x1 for a vertical line
		pixReq.y      = rowCnt;     // stays at y1 for a horizontal line
		pixReq.colour = regs.colour[`GFX_COLOUR_W-1:0];
	end

	////////////////////////////////////////////////////////////
	// palette write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			palWe <= 1'b0;
		else
			palWe <= (state == gfxPkg::sPalette) && !vsyncN;   // single pulse
	end

	always_ff @(posedge Clk) begin
		palAddr <= regs.colour[`GFX_PAL_ADDR_W-1:0];
		palRgb  <= {regs.x1[7:0], regs.y1};     // RR from x1, GGBB from y1
	end

	assign pal = '{we: palWe, addr: palAddr, rgb: palRgb};

endmodule

`default_nettype wire

// File: hw/frameBufferPort.sv
`timescale 1ns/1ps
`default_nettype none

module frameBufferPort (
	input  wire logic              Clk,
	input  wire logic              rstN,
	input  wire gfxPkg::pixelReq_t pixReq,
	input  wire gfxPkg::word_t     sramData,
	output gfxPkg::sramReq_t       sram,
	output gfxPkg::colour_t        readPixel,
	output logic                   readValid
);

	gfxPkg::sramReq_t sramNext;
	logic rdValid1;     // read sitting in the sram output register
	logic rdOdd1;       // x bit 0 of that read
	logic rdOdd2;       // x bit 0 lined up with sramData

	////////////////////////////////////////////////////////////
	// request to sram word
	////////////////////////////////////////////////////////////

	always_comb begin
		sramNext.addr  = {pixReq.y, pixReq.x[9:1]};        // two pixels per word
		sramNext.wdata = {pixReq.colour, pixReq.colour};   // lane strobe picks the byte
		sramNext.udsN  = 1'b1;
		sramNext.ldsN  = 1'b1;
		sramNext.rw    = 1'b1;
		if (pixReq.write) begin
			sramNext.udsN = pixReq.x[0];    // even pixel in the upper byte
			sramNext.ldsN = !pixReq.x[0];
			sramNext.rw   = 1'b0;
		end else if (pixReq.read) begin
			sramNext.udsN = 1'b0;           // fetch the whole word
			sramNext.ldsN = 1'b0;
		end
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			sram <= '{addr: '0, wdata: '0, udsN: 1'b1, ldsN: 1'b1, rw: 1'b1};
		else
			sram <= sramNext;
	end

	////////////////////////////////////////////////////////////
	// read return pipe
	////////////////////////////////////////////////////////////

	// one stage per sram register, so back to back reads are fine
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			rdValid1  <= 1'b0;
			readValid <= 1'b0;
		end else begin
			rdValid1  <= pixReq.read && !pixReq.write;
			readValid <= rdValid1;
		end
	end

	always_ff @(posedge Clk) begin
		rdOdd1 <= pixReq.x[0];
		rdOdd2 <= rdOdd1;
	end

	assign readPixel = rdOdd2 ? sramData[7:0] : sramData[15:8];

endmodule

`default_nettype wire

// File: hw/graphicsController.sv
`timescale 1ns/1ps
`default_nettype none

module graphicsController (
	input  wire logic            Clk,
	input  wire logic            rstN,
	input  wire gfxPkg::cpuBus_t bus,
	input  wire logic            vsyncN,    // low during vertical blanking
	input  wire gfxPkg::word_t   sramData,
	output gfxPkg::word_t        readData,
	output gfxPkg::sramReq_t     sram,
	output gfxPkg::palWrite_t    pal
);

	gfxPkg::drawRegs_t regs;
	logic start;
	logic done;
	gfxPkg::pixelReq_t pixReq;
	gfxPkg::colour_t readPixel;
	logic readValid;

	// cpu side registers and status
	gfxRegFile regFileI (
		.Clk       (Clk),
		.rstN      (rstN),
		.bus       (bus),
		.done      (done),
		.readPixel (readPixel),
		.readValid (readValid),
		.regs      (regs),
		.start     (start),
		.readData  (readData)
	);

	// command engine
	drawSequencer seqI (
		.Clk    (Clk),
		.rstN   (rstN),
		.regs   (regs),
		.start  (start),
		.vsyncN (vsyncN),
		.pixReq (pixReq),
		.pal    (pal),
		.done   (done)
	);

	// frame buffer memory side
	frameBufferPort fbPortI (
		.Clk       (Clk),
		.rstN      (rstN),
		.pixReq    (pixReq),
		.sramData  (sramData),
		.sram      (sram),
		.readPixel (readPixel),
		.readValid (readValid)
	);

endmodule

`default_nettype wire

// File: bench/graphicsController_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module graphicsControllerAsserts (
	input wire logic                Clk,
	input wire logic                rstN,
	input wire gfxPkg::cpuBus_t     bus,
	input wire logic                vsyncN,
	input wire gfxPkg::word_t       readData,
	input wire gfxPkg::sramReq_t    sram,
	input wire gfxPkg::palWrite_t   pal,
	input wire gfxPkg::gfxState_t   seqState    // draw engine state
);

	logic statusRead;   // cpu reading offset 0

	assign statusRead = !bus.csN && !bus.asN && bus.rw && (bus.address[15:1] == 15'd0);

	////////////////////////////////////////////////////////////
	// palette and sram
	////////////////////////////////////////////////////////////

	// we is registered, so vsync was low on the edge that raised it
	palWeInBlanking: assert property (@(posedge Clk) disable iff (!rstN)
		pal.we |-> $past(!vsyncN))
		else $error("pal.we raised without vertical sync low");

	sramSingleLane: assert property (@(posedge Clk) disable iff (!rstN)
		!sram.rw |-> (sram.udsN || sram.ldsN))  // one pixel per write
		else $error("sram write with both byte strobes low");

	////////////////////////////////////////////////////////////
	// status
	////////////////////////////////////////////////////////////

	statusMatchesIdle: assert property (@(posedge Clk) disable iff (!rstN)
		(statusRead && readData[0]) |-> (seqState == gfxPkg::sIdle))
		else $error("status idle bit set while the sequencer is busy");

endmodule

bind graphicsController graphicsControllerAsserts assertsI (
	.Clk      (Clk),
	.rstN     (rstN),
	.bus      (bus),
	.vsyncN   (vsyncN),
	.readData (readData),
	.sram     (sram),
	.pal      (pal),
	.seqState (seqI.state)
);

`default_nettype wire

// File: bench/graphicsControllerTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "gfx_defines.svh"

module graphicsControllerTb;

	localparam int NUM_TESTS     = 9;
	localparam int TIMEOUT_POLLS = 2000;    // status reads before giving up
	localparam gfxPkg::cpuBus_t BUS_IDLE = '{address: '0, writeData: '0, csN: 1'b1,
		asN: 1'b1, udsN: 1'b1, ldsN: 1'b1, rw: 1'b1};

	// one row of the stimulus table
	typedef struct packed {
		gfxPkg::word_t cmd;
		gfxPkg::word_t x1;
		gfxPkg::word_t y1;
		gfxPkg::word_t x2;
		gfxPkg::word_t y2;
		gfxPkg::word_t colour;
	} testVec_t;

	logic Clk = 1'b0;
	logic rstN;
	logic vsyncN = 1'b1;
	gfxPkg::cpuBus_t bus;
	gfxPkg::word_t sramData = '0;
	gfxPkg::word_t readData;
	gfxPkg::sramReq_t sram;
	gfxPkg::palWrite_t pal;

	gfxPkg::word_t mem [gfxPkg::sramAddr_t];     // words written so far
	gfxPkg::word_t shadow [gfxPkg::sramAddr_t];  // expected frame
	testVec_t tests [NUM_TESTS];
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int sramWrites = 0;
	int palPulses = 0;
	int palEarly = 0;           // pulses with vsync high on the edge before
	logic vsyncLast = 1'b1;
	logic timedOut = 1'b0;
	gfxPkg::palWrite_t palSeen;

	graphicsController dut_i (
		.Clk      (Clk),
		.rstN     (rstN),
		.bus      (bus),
		.vsyncN   (vsyncN),
		.sramData (sramData),
		.readData (readData),
		.sram     (sram),
		.pal      (pal)
	);

	always #5 Clk = ~Clk;       // 100 MHz

	always @(posedge Clk) begin
		vsyncN <= ($urandom % 4) != 0;     // blanking about a quarter of the time
	end

	////////////////////////////////////////////////////////////
	// sram model and frame helpers
	////////////////////////////////////////////////////////////

	// background fill that depends on every address bit
	function automatic gfxPkg::word_t bgWord(input gfxPkg::sramAddr_t a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h5c3};
	endfunction

	function automatic gfxPkg::word_t frameRead(input gfxPkg::sramAddr_t a);
		return mem.exists(a) ? mem[a] : bgWord(a);
	endfunction

	function automatic gfxPkg::word_t expectRead(input gfxPkg::sramAddr_t a);
		return shadow.exists(a) ? shadow[a] : bgWord(a);
	endfunction

	// even column sits in the upper byte
	function automatic gfxPkg::colour_t expectPixel(input int x, input int y);
		gfxPkg::word_t w;
		w = expectRead({`GFX_Y_W'(y), 9'(x / 2)});
		return (x % 2 == 1) ? w[7:0] : w[15:8];
	endfunction

	always @(posedge Clk) begin : sramModel
		gfxPkg::word_t cur;
		if (rstN && !sram.rw) begin    // no writes while the port is in reset
			cur = frameRead(sram.addr);
			if (!sram.udsN)
				cur[15:8] = sram.wdata[15:8];
			if (!sram.ldsN)
				cur[7:0] = sram.wdata[7:0];
			mem[sram.addr] = cur;
		end
		sramData <= frameRead(sram.addr);   // one cycle read latency
	end

	// count what leaves the DUT on the falling edge
	always @(negedge Clk) begin
		if (rstN) begin
			if (!sram.rw)
				sramWrites++;
			if (pal.we) begin
				palPulses++;
				palSeen = pal;
				if (vsyncLast)
					palEarly++;
			end
		end
		vsyncLast = vsyncN;
	end

	task automatic paintPixel(input int x, input int y, input gfxPkg::colour_t c);
		gfxPkg::sramAddr_t a;
		gfxPkg::word_t w;
		a = {`GFX_Y_W'(y), 9'(x / 2)};
		w = expectRead(a);
		if (x % 2 == 1)
			w[7:0] = c;
		else
			w[15:8] = c;
		shadow[a] = w;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, expVal, actVal);
			errors++;
		end
	endtask

	// frame words around the drawn area plus one word of margin
	task automatic compareRegion(input int xLo, input int xHi, input int yLo, input int yHi);
		int rowLo;
		int rowHi;
		int colLo;
		int colHi;
		gfxPkg::sramAddr_t a;
		rowLo = (yLo > 0) ? yLo - 1 : 0;
		rowHi = (yHi < 511) ? yHi + 1 : 511;
		colLo = (xLo > 1) ? xLo / 2 - 1 : 0;
		colHi = (xHi < 1022) ? xHi / 2 + 1 : 511;
		for (int y = rowLo; y <= rowHi; y++) begin
			for (int c = colLo; c <= colHi; c++) begin
				a = {`GFX_Y_W'(y), 9'(c)};
				checkValue($sformatf("mem[%05h]", a), 32'(expectRead(a)), 32'(frameRead(a)));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// cpu bus
	////////////////////////////////////////////////////////////

	task automatic busWrite(input logic [6:0] offs, input gfxPkg::word_t data,
		input logic udsN, input logic ldsN);
		@(posedge Clk);
		bus <= '{address: {8'h00, offs, 1'b0}, writeData: data, csN: 1'b0, asN: 1'b0,
			udsN: udsN, ldsN: ldsN, rw: 1'b0};
		@(posedge Clk);
		bus <= BUS_IDLE;
	endtask

	task automatic busRead(input logic [6:0] offs, output gfxPkg::word_t data);
		@(posedge Clk);
		bus <= '{address: {8'h00, offs, 1'b0}, writeData: '0, csN: 1'b0, asN: 1'b0,
			udsN: 1'b0, ldsN: 1'b0, rw: 1'b1};
		@(negedge Clk);
		data = readData;
		@(posedge Clk);
		bus <= BUS_IDLE;
	endtask

	// upper byte then lower byte
	task automatic regWriteBytes(input logic [6:0] offs, input gfxPkg::word_t data);
		busWrite(offs, data, 1'b0, 1'b1);
		busWrite(offs, data, 1'b1, 1'b0);
	endtask

	task automatic waitIdle(output logic ok);
		gfxPkg::word_t st;
		int polls;
		st = '0;
		polls = 0;
		while (!st[0] && polls < TIMEOUT_POLLS) begin
			busRead(`REG_CMD, st);
			polls++;
		end
		ok = st[0];
	endtask

	////////////////////////////////////////////////////////////
	// one table row
	////////////////////////////////////////////////////////////

	task automatic runTest(input int t);
		testVec_t v;
		int errBefore;
		int writesBefore;
		int palBefore;
		int earlyBefore;
		int expWrites;
		int xLo;
		int yLo;
		int xMax;
		int yMax;
		logic ok;
		gfxPkg::word_t rd;
		v = tests[t];
		errBefore = errors;
		xLo = int'(v.x1[`GFX_X_W-1:0]);
		yLo = int'(v.y1[`GFX_Y_W-1:0]);
		xMax = (int'(v.x2[`GFX_X_W-1:0]) > xLo) ? int'(v.x2[`GFX_X_W-1:0]) : xLo;
		yMax = (int'(v.y2[`GFX_Y_W-1:0]) > yLo) ? int'(v.y2[`GFX_Y_W-1:0]) : yLo;
		regWriteBytes(`REG_X1, v.x1);
		regWriteBytes(`REG_Y1, v.y1);
		regWriteBytes(`REG_X2, v.x2);
		regWriteBytes(`REG_Y2, v.y2);
		regWriteBytes(`REG_COLOUR, v.colour);
		writesBefore = sramWrites;
		palBefore = palPulses;
		earlyBefore = palEarly;
		busWrite(`REG_CMD, v.cmd, 1'b0, 1'b0);  // whole word write starts the command
		waitIdle(ok);
		if (!ok) begin
			$display("test %0d cmd %04h: status never returned to idle", t, v.cmd);
			timedOut = 1'b1;
			failed++;
			return;
		end
		repeat (2) @(negedge Clk);  // last write reaches the sram model
		expWrites = 0;
		case (v.cmd)
			`CMD_PUTPIXEL: begin
				paintPixel(xLo, yLo, v.colour[7:0]);
				expWrites = 1;
			end
			`CMD_HLINE: begin
				for (int x = xLo; x <= xMax; x++)
					paintPixel(x, yLo, v.colour[7:0]);
				expWrites = xMax - xLo + 1;
			end
			`CMD_VLINE: begin
				for (int y = yLo; y <= yMax; y++)
					paintPixel(xLo, y, v.colour[7:0]);
				expWrites = yMax - yLo + 1;
			end
			`CMD_GETPIXEL: begin
				busRead(`REG_COLOUR, rd);
				checkValue("colour latch", 32'(expectPixel(xLo, yLo)), 32'(rd));
			end
			default: ;  // palette and unknown touch no frame word
		endcase
		if (v.cmd != `CMD_HLINE)
			xMax = xLo;
		if (v.cmd != `CMD_VLINE)
			yMax = yLo;
		checkValue("sram writes", 32'(expWrites), 32'(sramWrites - writesBefore));
		checkValue("pal.we pulses", (v.cmd == `CMD_PALETTE) ? 32'd1 : 32'd0,
			32'(palPulses - palBefore));
		checkValue("pal.we outside vsync", 32'd0, 32'(palEarly - earlyBefore));
		if (v.cmd == `CMD_PALETTE) begin
			checkValue("pal.addr", 32'(v.colour[5:0]), 32'(palSeen.addr));
			checkValue("pal.rgb", 32'({v.x1[7:0], v.y1}), 32'(palSeen.rgb));
		end
		compareRegion(xLo, xMax, yLo, yMax);
		if (errors == errBefore) begin
			$display("test %0d cmd %04h: ok", t, v.cmd);
			passed++;
		end else begin
			$display("test %0d cmd %04h: %0d mismatches", t, v.cmd, errors - errBefore);
			failed++;
		end
	endtask

	initial begin
		gfxPkg::word_t status;
		void'($urandom(32'h8f39_f101));
		rstN = 1'b0;
		bus = BUS_IDLE;
		//                cmd            x1        y1        x2         y2        colour
		tests[0] = '{`CMD_PUTPIXEL, 16'd100,  16'd20,   16'd1023, 16'd511,  16'h003c};
		tests[1] = '{`CMD_PUTPIXEL, 16'd101,  16'd20,   16'd1023, 16'd511,  16'h00a5};
		tests[2] = '{`CMD_GETPIXEL, 16'd100,  16'd20,   16'd0,    16'd0,    16'h0000};
		tests[3] = '{`CMD_GETPIXEL, 16'd101,  16'd20,   16'd0,    16'd0,    16'h0000};
		tests[4] = '{`CMD_HLINE,    16'd30,   16'd50,   16'd45,   16'd0,    16'h0077};
		tests[5] = '{`CMD_HLINE,    16'd300,  16'd60,   16'd290,  16'd0,    16'h0019};
		tests[6] = '{`CMD_VLINE,    16'd511,  16'd100,  16'd0,    16'd110,  16'h00e2};
		tests[7] = '{`CMD_PALETTE,  16'h01f3, 16'hbeef, 16'd0,    16'd0,    16'h002b};
		tests[8] = '{16'h0055,      16'd200,  16'd200,  16'd0,    16'd0,    16'h0066};
		repeat (5) @(posedge Clk);
		rstN <= 1'b1;
		busRead(`REG_CMD, status);
		checkValue("status after reset", 32'd1, 32'(status));
		if (errors == 0) begin
			$display("reset status: ok");
			passed++;
		end else begin
			$display("reset status: %0d mismatches", errors);
			failed++;
		end
		for (int t = 0; t < NUM_TESTS && !timedOut; t++)
			runTest(t);
		$display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
		if (errors == 0 && failed == 0 && !timedOut)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/gfxPkg.sv
hw/gfxRegFile.sv
hw/drawSequencer.sv
hw/frameBufferPort.sv
hw/graphicsController.sv
bench/graphicsController_asserts.sv
bench/graphicsControllerTb.sv

// File: Makefile
SIM     := verilator
TOP     := graphicsControllerTb
FLIST   := flist.f
FLAGS   := --binary --timing --assert -j 0
OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
LOG     := sim.log

SRCS    := $(shell grep -v '^+' $(FLIST))
HDRS    := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
